// File: cpu_alu.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_params.svh"

module cpu_alu
    import cpu_pkg::*;
(
    input  wire alu_op_t        op,
    input  wire [`XLEN-1:0]     a,
    input  wire [`XLEN-1:0]     b,
    output logic [`XLEN-1:0]    result,
    output logic                equal
);

    assign equal = (a == b);   // BEQ decision

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_EQ:  result = {{(`XLEN-1){1'b0}}, equal};
            default: result = a + b;
        endcase
    end

endmodule

`default_nettype wire

// File: cpu_boot.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_params.svh"

module cpu_boot
    import cpu_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,
    input  wire                load_valid,
    input  wire [`XLEN-1:0]    load_data,
    output logic               load_ready,
    imem_load_if.source        ld
);

    localparam int IDX_W = $clog2(`IMEM_WORDS);
    localparam int AW    = `ADDR_W;

    boot_state_t      state;
    logic [IDX_W-1:0] wcnt;      // next word slot
    logic             accept;

    assign load_ready = (state == BOOT_LOAD);
    assign accept     = load_valid && load_ready;

    // every accepted word is written straight into imem
    assign ld.wrt_en   = accept;
    assign ld.wrt_addr = AW'({wcnt, 2'b00});
    assign ld.wrt_data = load_data;
    assign ld.run      = (state == BOOT_RUN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= BOOT_LOAD;
            wcnt  <= '0;
        end else if (accept) begin
            wcnt <= wcnt + 1'b1;
            if (wcnt == IDX_W'(`IMEM_WORDS - 1)) begin
                state <= BOOT_RUN;   // memory full
            end
        end
    end

    // run starts right after the last imem word is written
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ld.run) |->
            $past(ld.wrt_en) && $past(ld.wrt_addr) == AW'((`IMEM_WORDS - 1) * 4))
        else $error("boot finished without writing the last imem word");

endmodule

`default_nettype wire

// File: cpu_dmem.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_params.svh"

module cpu_dmem (
    input  wire                 clk,
    input  wire                 rst_n,
    dmem_port_if.slave          dm,
    output logic                host_wr_valid,
    input  wire                 host_wr_ready,
    output logic [`ADDR_W-1:0]  host_wr_addr,
    output logic [`XLEN-1:0]    host_wr_data
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] ram [`DMEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             is_host;

    ////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////

    assign is_host = (dm.addr >= `HOST_BASE);
    assign idx     = dm.addr[IDX_W+1:2];   // word index

    ////////////////////////////////////////////////////////////
    // host write channel
    ////////////////////////////////////////////////////////////

    // store sits in MEM until the host takes it
    assign host_wr_valid = dm.wrt_en && is_host;
    assign host_wr_addr  = dm.addr;
    assign host_wr_data  = dm.wrt_data;
    assign dm.hold       = host_wr_valid && !host_wr_ready;

    ////////////////////////////////////////////////////////////
    // local RAM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (dm.wrt_en && !is_host) begin
            ram[idx] <= dm.wrt_data;
        end
    end

    always_ff @(posedge clk) begin
        if (dm.rd_en) begin
            dm.rd_data <= is_host ? '0 : ram[idx];   // host space reads zero
        end
    end

    // relies on the pipeline freezing MEM while held
    assert property (@(posedge clk) disable iff (!rst_n)
        host_wr_valid && !host_wr_ready |=>
            host_wr_valid && $stable(host_wr_addr) && $stable(host_wr_data))
        else $error("host write changed before ready");

endmodule

`default_nettype wire

// File: cpu_hazard.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_params.svh"

module cpu_hazard
    import isa_pkg::*;
(
    input  wire instr_u  dec_instr,
    input  wire [3:0]    ex_rd,
    input  wire [3:0]    mem_rd,
    input  wire [3:0]    wb_rd,
    input  wire          ex_wen,
    input  wire          mem_wen,
    input  wire          wb_wen,
    input  wire          branch_busy,
    output logic         stall
);

    localparam int NR = `REG_COUNT;

    logic [NR-1:0] busy;       // registers with a write still in flight
    logic          use_rs, use_rt, use_rd;
    logic          raw;

    assign busy = ((ex_wen  ? NR'(1) << ex_rd  : '0) |
                   (mem_wen ? NR'(1) << mem_rd : '0) |
                   (wb_wen  ? NR'(1) << wb_rd  : '0)) & ~NR'(1);   // r0 never waits

    always_comb begin
        use_rs = 1'b0;
        use_rt = 1'b0;
        use_rd = 1'b0;
        case (dec_instr.r.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            OP_ADDI, OP_LW: use_rs = 1'b1;
            OP_SW, OP_BEQ: begin
                use_rs = 1'b1;
                use_rd = 1'b1;   // store data / compare operand
            end
            default: ;
        endcase
    end

    assign raw = (use_rs && busy[dec_instr.i.rs]) ||
                 (use_rt && busy[dec_instr.r.rt]) ||
                 (use_rd && busy[dec_instr.i.rd]);

    assign stall = raw || branch_busy;

endmodule

`default_nettype wire

// File: cpu_ifs.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_params.svh"

// boot loader to instruction memory, plus the run flag for fetch
interface imem_load_if;
    logic                wrt_en;
    logic [`ADDR_W-1:0]  wrt_addr;   // byte address
    logic [`XLEN-1:0]    wrt_data;
    logic                run;

    modport source (output wrt_en, wrt_addr, wrt_data, run);
    modport sink   (input wrt_en, wrt_addr, wrt_data);
    modport pipe   (input run);
endinterface

// MEM stage access, rd_data comes back one cycle later
interface dmem_port_if;
    logic [`ADDR_W-1:0]  addr;
    logic [`XLEN-1:0]    wrt_data;
    logic                wrt_en;
    logic                rd_en;
    logic [`XLEN-1:0]    rd_data;
    logic                hold;       // freezes the whole pipeline

    modport master (output addr, wrt_data, wrt_en, rd_en, input rd_data, hold);
    modport slave  (input addr, wrt_data, wrt_en, rd_en, output rd_data, hold);
endinterface

`default_nettype wire

// File: cpu_imem.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_params.svh"

module cpu_imem
    import isa_pkg::*;
(
    input  wire                clk,
    imem_load_if.sink          ld,
    input  wire [`ADDR_W-1:0]  rd_addr,
    output instr_u             rd_instr
);

    localparam int IDX_W = $clog2(`IMEM_WORDS);

    logic [`XLEN-1:0] mem [`IMEM_WORDS];

    // boot write port
    always_ff @(posedge clk) begin
        if (ld.wrt_en) begin
            mem[ld.wrt_addr[IDX_W+1:2]] <= ld.wrt_data;
        end
    end

    // fetch port, one cycle latency
    always_ff @(posedge clk) begin
        rd_instr <= mem[rd_addr[IDX_W+1:2]];
    end

endmodule

`default_nettype wire

// File: cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath and register file
`define XLEN        32
`define REG_COUNT   16

// memory depths in words
`define IMEM_WORDS  64   // also the boot word count
`define DMEM_WORDS  64

// byte address space seen by the core and the host
`define ADDR_W      16

// stores at or above this go out to the host
`define HOST_BASE   16'h9000

`endif

// File: cpu_pipeline.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_params.svh"

module cpu_pipeline
    import isa_pkg::*;
    import cpu_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,
    imem_load_if.pipe          ld,
    output logic [`ADDR_W-1:0] imem_addr,
    input  wire instr_u        imem_instr,
    dmem_port_if.master        dm,
    output logic               halted
);

    localparam int AW = `ADDR_W;
    localparam int XW = `XLEN;

    logic [AW-1:0] fetch_pc, id_pc, ex_pc, br_target;
    logic          id_valid, fetch_stop;
    instr_u        id_instr, ex_instr, mem_instr, wb_instr;
    logic [XW-1:0] rf [`REG_COUNT];
    logic [XW-1:0] rs_val, rt_val, rd_val, imm_ext, id_b;
    logic [XW-1:0] ex_a, ex_b, ex_d, alu_res;
    logic [XW-1:0] mem_res, mem_d, wb_res, wb_data;
    logic          alu_eq, take_branch, branch_busy, stall, advance;
    logic          ex_wen, mem_wen, wb_wen;
    alu_op_t       alu_op;

    function automatic logic writes_rd(input instr_u ins);
        logic wr;
        case (ins.r.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_LW: wr = 1'b1;
            default: wr = 1'b0;
        endcase
        return wr && (ins.r.rd != 4'd0);
    endfunction

    assign advance = ld.run && !dm.hold;
    assign ex_wen  = writes_rd(ex_instr);
    assign mem_wen = writes_rd(mem_instr);
    assign wb_wen  = writes_rd(wb_instr);

    ////////////////////////////////////////////////////////////
    // fetch
    ////////////////////////////////////////////////////////////

    // re-read the ID word while frozen, since imem output is not held
    always_comb begin
        if (take_branch) imem_addr = br_target;
        else if (stall || dm.hold) imem_addr = id_pc;
        else imem_addr = fetch_pc;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pc   <= '0;
            id_pc      <= '0;
            id_valid   <= 1'b0;
            fetch_stop <= 1'b0;
        end else if (advance) begin
            if (take_branch) begin
                id_pc    <= br_target;   // wrong-path word in ID is dropped
                id_valid <= 1'b1;
                fetch_pc <= br_target + AW'(4);
            end else if (!stall) begin
                if (fetch_stop || id_instr.r.op == OP_HALT) begin
                    fetch_stop <= 1'b1;
                    id_valid   <= 1'b0;
                end else begin
                    id_pc    <= fetch_pc;
                    id_valid <= 1'b1;
                    fetch_pc <= fetch_pc + AW'(4);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // decode and register read
    ////////////////////////////////////////////////////////////

    assign id_instr = id_valid ? imem_instr : '0;
    assign imm_ext  = {{(XW-16){id_instr.i.imm[15]}}, id_instr.i.imm};

    always_comb begin
        rs_val = (id_instr.i.rs == 4'd0) ? '0 : rf[id_instr.i.rs];
        rt_val = (id_instr.r.rt == 4'd0) ? '0 : rf[id_instr.r.rt];
        rd_val = (id_instr.i.rd == 4'd0) ? '0 : rf[id_instr.i.rd];
        case (id_instr.r.op)
            OP_ADDI, OP_LW, OP_SW: id_b = imm_ext;
            OP_BEQ:                id_b = rd_val;   // compared against rs
            default:               id_b = rt_val;
        endcase
    end

    cpu_hazard u_haz (
        .dec_instr   (id_instr),
        .ex_rd       (ex_instr.r.rd),
        .mem_rd      (mem_instr.r.rd),
        .wb_rd       (wb_instr.r.rd),
        .ex_wen      (ex_wen),
        .mem_wen     (mem_wen),
        .wb_wen      (wb_wen),
        .branch_busy (branch_busy),
        .stall       (stall)
    );

    ////////////////////////////////////////////////////////////
    // stage registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_instr  <= '0;
            mem_instr <= '0;
            wb_instr  <= '0;
        end else if (advance) begin
            ex_instr  <= stall ? '0 : id_instr;   // bubble on stall
            mem_instr <= ex_instr;
            wb_instr  <= mem_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && !stall) begin
            ex_a  <= rs_val;
            ex_b  <= id_b;
            ex_d  <= rd_val;
            ex_pc <= id_pc;
        end
        if (advance) begin
            mem_res <= alu_res;
            mem_d   <= ex_d;
            wb_res  <= mem_res;
        end
    end

    // a stalled instruction is read again from imem and never leaks into EX
    assert property (@(posedge clk) disable iff (!rst_n)
        stall && advance && !take_branch |=>
            ex_instr.r.op == OP_NOP && id_instr == $past(id_instr))
        else $error("stalled instruction lost or leaked into EX");

    ////////////////////////////////////////////////////////////
    // execute
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (ex_instr.r.op)
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_BEQ:  alu_op = ALU_EQ;
            default: alu_op = ALU_ADD;   // add, addi, address calc
        endcase
    end

    cpu_alu u_alu (
        .op     (alu_op),
        .a      (ex_a),
        .b      (ex_b),
        .result (alu_res),
        .equal  (alu_eq)
    );

    assign branch_busy = (ex_instr.r.op == OP_BEQ);
    assign take_branch = branch_busy && alu_eq;
    assign br_target   = ex_pc + AW'(4) + {ex_instr.i.imm[AW-3:0], 2'b00};

    ////////////////////////////////////////////////////////////
    // memory and writeback
    ////////////////////////////////////////////////////////////

    assign dm.addr     = mem_res[AW-1:0];
    assign dm.wrt_data = mem_d;
    assign dm.wrt_en   = (mem_instr.r.op == OP_SW);
    assign dm.rd_en    = (mem_instr.r.op == OP_LW);

    assign wb_data = (wb_instr.r.op == OP_LW) ? dm.rd_data : wb_res;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                rf[i] <= '0;
            end
        end else if (wb_wen) begin
            rf[wb_instr.r.rd] <= wb_data;
        end
    end

    // earlier host writes are already done once HALT is in WB
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) halted <= 1'b0;
        else if (wb_instr.r.op == OP_HALT) halted <= 1'b1;
    end

endmodule

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef enum logic [1:0] {
        BOOT_LOAD = 2'd0,   // taking words from the host
        BOOT_RUN  = 2'd1
    } boot_state_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_EQ  = 3'd4     // branch compare
    } alu_op_t;

endpackage

`default_nettype wire

// File: cpu_top.f
+incdir+.
isa_pkg.sv
cpu_pkg.sv
cpu_ifs.sv
cpu_boot.sv
cpu_imem.sv
cpu_alu.sv
cpu_hazard.sv
cpu_pipeline.sv
cpu_dmem.sv
cpu_top.sv
tb_cpu_top.sv

// File: cpu_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_params.svh"

module cpu_top
    import isa_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 load_valid,
    output logic                load_ready,
    input  wire [`XLEN-1:0]     load_data,
    output logic                host_wr_valid,
    input  wire                 host_wr_ready,
    output logic [`ADDR_W-1:0]  host_wr_addr,
    output logic [`XLEN-1:0]    host_wr_data,
    output logic                halted
);

    logic [`ADDR_W-1:0] imem_addr;
    instr_u             imem_instr;

    imem_load_if ld_if ();
    dmem_port_if dm_if ();

    cpu_boot u_boot (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_valid (load_valid),
        .load_data  (load_data),
        .load_ready (load_ready),
        .ld         (ld_if.source)
    );

    cpu_imem u_imem (
        .clk      (clk),
        .ld       (ld_if.sink),
        .rd_addr  (imem_addr),
        .rd_instr (imem_instr)
    );

    cpu_pipeline u_pipe (
        .clk        (clk),
        .rst_n      (rst_n),
        .ld         (ld_if.pipe),
        .imem_addr  (imem_addr),
        .imem_instr (imem_instr),
        .dm         (dm_if.master),
        .halted     (halted)
    );

    cpu_dmem u_dmem (
        .clk           (clk),
        .rst_n         (rst_n),
        .dm            (dm_if.slave),
        .host_wr_valid (host_wr_valid),
        .host_wr_ready (host_wr_ready),
        .host_wr_addr  (host_wr_addr),
        .host_wr_data  (host_wr_data)
    );

endmodule

`default_nettype wire

// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

    // NOP must stay at zero, bubbles are all-zero words
    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_ADD  = 8'h10,
        OP_SUB  = 8'h11,
        OP_AND  = 8'h12,
        OP_OR   = 8'h13,
        OP_ADDI = 8'h18,
        OP_BEQ  = 8'h31,
        OP_LW   = 8'h80,
        OP_SW   = 8'h87,
        OP_HALT = 8'hff
    } opcode_t;

    typedef struct packed {
        opcode_t     op;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [3:0]  rt;
        logic [11:0] unused;
    } r_view_t;

    typedef struct packed {
        opcode_t     op;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [15:0] imm;    // sign extended by decode
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_u;

endpackage

`default_nettype wire

// File: tb_cpu_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_params.svh"

module tb_cpu_top
    import isa_pkg::*;
();

    localparam int MAX_STEPS    = 1000;   // model step limit per program
    localparam int MAX_WRITES   = 1024;
    localparam int HALT_TIMEOUT = 3000;   // cycles from boot end to halted
    // five programs of one boot and a 4000-cycle run budget each
    localparam int WATCHDOG_NS  = 5 * (`IMEM_WORDS + 4000) * 8;

    logic                clk;
    logic                rst_n;
    logic                load_valid;
    logic [`XLEN-1:0]    load_data;
    logic                host_wr_ready;
    logic                load_ready;
    logic                host_wr_valid;
    logic [`ADDR_W-1:0]  host_wr_addr;
    logic [`XLEN-1:0]    host_wr_data;
    logic                halted;

    logic [`XLEN-1:0]    prog [`IMEM_WORDS];
    logic [`ADDR_W-1:0]  exp_addr [MAX_WRITES];
    logic [`XLEN-1:0]    exp_data [MAX_WRITES];
    int                  exp_count = 0;
    int                  got_count = 0;
    int                  errors = 0;
    int                  tests_run = 0;
    int                  tests_passed = 0;
    integer              seed = 32'h9683a0dd;
    logic                ready_random = 1'b0;

    cpu_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_valid    (load_valid),
        .load_ready    (load_ready),
        .load_data     (load_data),
        .host_wr_valid (host_wr_valid),
        .host_wr_ready (host_wr_ready),
        .host_wr_addr  (host_wr_addr),
        .host_wr_data  (host_wr_data),
        .halted        (halted)
    );

    always #4 clk = ~clk;

    // host ready is random only while a back-pressure program runs
    always @(posedge clk) begin
        #1;
        host_wr_ready = ready_random ? (({$random(seed)} % 2) == 0) : 1'b1;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, want);
        errors++;
    endtask

    // completed transfers against the predicted sequence
    always @(negedge clk) begin
        if (rst_n && host_wr_valid && host_wr_ready) begin
            if (got_count >= exp_count) begin
                $display("extra host write at %0t ns to %h with data %h",
                         $time, host_wr_addr, host_wr_data);
                errors++;
            end else begin
                if (host_wr_addr !== exp_addr[got_count]) begin
                    report_mismatch("host_wr_addr", host_wr_addr, exp_addr[got_count]);
                end
                if (host_wr_data !== exp_data[got_count]) begin
                    report_mismatch("host_wr_data", host_wr_data, exp_data[got_count]);
                end
            end
            got_count++;
        end
    end

    ////////////////////////////////////////////////////////////
    // instruction encoding and ISA model
    ////////////////////////////////////////////////////////////

    function automatic logic [`XLEN-1:0] rtype_word(input opcode_t op, input int rd,
                                                    input int rs, input int rt);
        instr_u w;
        w.r = {op, 4'(rd), 4'(rs), 4'(rt), 12'h000};
        return w;
    endfunction

    function automatic logic [`XLEN-1:0] itype_word(input opcode_t op, input int rd,
                                                    input int rs, input int imm);
        instr_u w;
        w.i = {op, 4'(rd), 4'(rs), 16'(imm)};
        return w;
    endfunction

    // runs prog to HALT, fills exp_addr/exp_data, returns the write count
    function automatic int predict_host_writes();
        logic [`XLEN-1:0]   regs [`REG_COUNT];
        logic [`XLEN-1:0]   ram [`DMEM_WORDS];
        logic [`XLEN-1:0]   a, b, d, imm, res;
        logic [`ADDR_W-1:0] pc, next_pc, addr;
        instr_u             ins;
        logic               wr, done;
        int                 i, n, steps;
        for (i = 0; i < `REG_COUNT; i++) begin
            regs[i] = '0;
        end
        pc    = '0;
        n     = 0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < MAX_STEPS) begin
            ins     = prog[(pc >> 2) % `IMEM_WORDS];
            a       = regs[ins.i.rs];
            b       = regs[ins.r.rt];
            d       = regs[ins.i.rd];
            imm     = {{(`XLEN-16){ins.i.imm[15]}}, ins.i.imm};
            addr    = `ADDR_W'(a + imm);
            next_pc = pc + 16'd4;
            res     = '0;
            wr      = 1'b1;
            case (ins.r.op)
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_ADDI: res = a + imm;
                OP_LW:   res = (addr >= `HOST_BASE) ? '0 : ram[(addr >> 2) % `DMEM_WORDS];
                OP_SW: begin
                    wr = 1'b0;
                    if (addr >= `HOST_BASE) begin
                        exp_addr[n] = addr;
                        exp_data[n] = d;
                        n++;
                    end else begin
                        ram[(addr >> 2) % `DMEM_WORDS] = d;
                    end
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (a == d) next_pc = pc + 16'd4 + `ADDR_W'(imm * 4);
                end
                OP_HALT: begin
                    wr   = 1'b0;
                    done = 1'b1;
                end
                default: wr = 1'b0;   // NOP
            endcase
            if (wr && ins.r.rd != 4'd0) regs[ins.r.rd] = res;
            pc = next_pc;
            steps++;
        end
        return n;
    endfunction

    ////////////////////////////////////////////////////////////
    // programs
    ////////////////////////////////////////////////////////////

    task automatic clear_program();
        int w;
        for (w = 0; w < `IMEM_WORDS; w++) begin
            prog[w] = rtype_word(OP_HALT, 0, 0, 0);
        end
    endtask

    // jumps to the last words so the whole image must be loaded
    task automatic build_boot_program();
        clear_program();
        prog[0]  = itype_word(OP_ADDI, 1, 0, 5);
        prog[1]  = itype_word(OP_ADDI, 2, 0, -3);
        prog[2]  = rtype_word(OP_ADD, 3, 1, 2);
        prog[3]  = itype_word(OP_SW, 3, 0, `HOST_BASE);
        prog[4]  = itype_word(OP_BEQ, 0, 0, 57);   // to word 62
        prog[62] = itype_word(OP_SW, 1, 0, `HOST_BASE + 4);
    endtask

    task automatic build_random_program(input int store_pct);
        int w, k, sel, rd, rs, rt;
        clear_program();
        for (w = 0; w < 7; w++) begin
            prog[w] = itype_word(OP_ADDI, w + 1, 0, $random(seed));
        end
        k = 0;
        for (w = 7; w < 55; w++) begin
            sel = {$random(seed)} % 100;
            rd  = {$random(seed)} % 8;   // r0 included on purpose
            rs  = {$random(seed)} % 8;
            rt  = {$random(seed)} % 8;
            if (sel < store_pct) begin
                prog[w] = itype_word(OP_SW, rd, 0, `HOST_BASE + 4 * k);
                k++;
            end else begin
                case (sel % 5)
                    0:       prog[w] = rtype_word(OP_ADD, rd, rs, rt);
                    1:       prog[w] = rtype_word(OP_SUB, rd, rs, rt);
                    2:       prog[w] = rtype_word(OP_AND, rd, rs, rt);
                    3:       prog[w] = rtype_word(OP_OR, rd, rs, rt);
                    default: prog[w] = itype_word(OP_ADDI, rd, rs, $random(seed));
                endcase
            end
        end
        for (w = 1; w < 8; w++) begin
            prog[54 + w] = itype_word(OP_SW, w, 0, `HOST_BASE + 4 * (k + w));
        end
    endtask

    task automatic build_hazard_program();
        clear_program();
        prog[0]  = itype_word(OP_ADDI, 1, 0, 7);
        prog[1]  = rtype_word(OP_ADD, 2, 1, 1);      // back to back
        prog[2]  = rtype_word(OP_SUB, 3, 2, 1);
        prog[3]  = itype_word(OP_SW, 3, 0, `HOST_BASE);
        prog[4]  = itype_word(OP_ADDI, 4, 0, 'h40);
        prog[5]  = itype_word(OP_SW, 2, 4, 0);       // internal ram
        prog[6]  = itype_word(OP_LW, 5, 4, 0);
        prog[7]  = rtype_word(OP_ADD, 6, 5, 1);      // load use
        prog[8]  = itype_word(OP_SW, 6, 0, `HOST_BASE + 4);
        prog[9]  = rtype_word(OP_OR, 7, 3, 6);
        prog[10] = rtype_word(OP_AND, 8, 7, 2);
        prog[11] = itype_word(OP_SW, 8, 4, 4);
        prog[12] = itype_word(OP_LW, 9, 4, 4);
        prog[13] = itype_word(OP_SW, 9, 0, `HOST_BASE + 8);
        prog[14] = itype_word(OP_ADDI, 10, 0, -1);
        prog[15] = itype_word(OP_LW, 10, 0, `HOST_BASE);   // host space reads 0
        prog[16] = itype_word(OP_SW, 10, 0, `HOST_BASE + 12);
    endtask

    task automatic build_branch_program();
        clear_program();
        prog[0]  = itype_word(OP_ADDI, 1, 0, 3);
        prog[1]  = itype_word(OP_ADDI, 2, 0, 3);
        prog[2]  = itype_word(OP_BEQ, 1, 2, 2);      // taken, skips two stores
        prog[3]  = itype_word(OP_SW, 1, 0, `HOST_BASE + 'h100);
        prog[4]  = itype_word(OP_SW, 2, 0, `HOST_BASE + 'h104);
        prog[5]  = itype_word(OP_SW, 1, 0, `HOST_BASE);
        prog[6]  = itype_word(OP_ADDI, 3, 0, 4);
        prog[7]  = itype_word(OP_BEQ, 3, 1, 5);      // not taken
        prog[8]  = itype_word(OP_SW, 3, 0, `HOST_BASE + 4);
        prog[9]  = itype_word(OP_ADDI, 4, 0, 3);
        prog[10] = itype_word(OP_ADDI, 4, 4, -1);    // countdown loop
        prog[11] = itype_word(OP_SW, 4, 0, `HOST_BASE + 8);
        prog[12] = itype_word(OP_BEQ, 4, 0, 1);
        prog[13] = itype_word(OP_BEQ, 0, 0, -4);     // back to word 10
        prog[14] = itype_word(OP_SW, 4, 0, `HOST_BASE + 12);
    endtask

    ////////////////////////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////////////////////////

    task automatic reset_dut();
        @(posedge clk);
        #1;
        rst_n      = 1'b0;
        load_valid = 1'b0;
        load_data  = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if (load_ready !== 1'b1) report_mismatch("load_ready", load_ready, 1);
        if (host_wr_valid !== 1'b0) report_mismatch("host_wr_valid", host_wr_valid, 0);
        if (halted !== 1'b0) report_mismatch("halted", halted, 0);
    endtask

    // streams prog with random gaps, then offers one more word that must be refused
    task automatic load_program();
        int idx;
        idx = 0;
        while (idx < `IMEM_WORDS) begin
            @(posedge clk);
            #1;
            load_valid = ({$random(seed)} % 4) != 0;
            load_data  = prog[idx];
            @(negedge clk);
            if (load_ready !== 1'b1) report_mismatch("load_ready", load_ready, 1);
            if (load_valid && load_ready) idx++;
        end
        @(posedge clk);
        #1;
        load_data = '0;
        repeat (3) begin
            @(negedge clk);
            if (load_ready !== 1'b0) report_mismatch("load_ready", load_ready, 0);
        end
        @(posedge clk);
        #1;
        load_valid = 1'b0;
    endtask

    task automatic run_program(input string name, input logic backpressure);
        int errs_before, cycles;
        logic saw_halt;
        errs_before  = errors;
        ready_random = 1'b0;
        exp_count    = predict_host_writes();
        got_count    = 0;
        reset_dut();
        load_program();
        @(negedge clk);
        ready_random = backpressure;
        cycles = 0;
        while (halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        saw_halt = (halted === 1'b1);
        if (!saw_halt) begin
            $display("%s: halted did not rise within %0d cycles", name, HALT_TIMEOUT);
            errors++;
        end else if (got_count != exp_count) begin
            report_mismatch("host write count at halt", got_count, exp_count);
        end
        repeat (10) @(negedge clk);
        if (got_count != exp_count) report_mismatch("host write count", got_count, exp_count);
        if (saw_halt && halted !== 1'b1) report_mismatch("halted", halted, 1);
        tests_run++;
        if (errors == errs_before) tests_passed++;
        $display("test %0d %s: %s, %0d of %0d host writes", tests_run, name,
                 (errors == errs_before) ? "PASS" : "FAIL", got_count, exp_count);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t ns, the run took too long", $time);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        load_valid    = 1'b0;
        load_data     = '0;
        host_wr_ready = 1'b1;
        build_boot_program();
        run_program("boot", 1'b0);
        build_random_program(25);
        run_program("arithmetic", 1'b0);
        build_hazard_program();
        run_program("hazards", 1'b0);
        build_branch_program();
        run_program("branches", 1'b0);
        build_random_program(45);
        run_program("back-pressure and halt", 1'b1);
        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
